/* Bender.yml */
package:
  name: fsab_memory

sources:
  - src/fsab_pkg.sv
  - src/fsab_queue_if.sv
  - src/fsab_req_fifo.sv
  - src/fsab_data_fifo.sv
  - src/fsab_mem_engine.sv
  - src/fsab_memory.sv
  - target: test
    files:
      - tests/tb_fsab_memory.sv

/* project.f */
src/fsab_pkg.sv
src/fsab_queue_if.sv
src/fsab_req_fifo.sv
src/fsab_data_fifo.sv
src/fsab_mem_engine.sv
src/fsab_memory.sv
tests/tb_fsab_memory.sv

/* src/fsab_data_fifo.sv */
`timescale 1ns/1ps

module fsab_data_fifo (
	input  logic                             clk,
	input  logic                             rst_b,
	input  logic                             fsabo_valid,
	input  logic [fsab_pkg::FSAB_DATA_W-1:0] fsabo_data,
	input  logic [fsab_pkg::FSAB_MASK_W-1:0] fsabo_mask,
	fsab_data_if.fifo                        q
);
	import fsab_pkg::*;

	fsab_word_u             data_ram [FSAB_DFIF_DEPTH];
	logic [FSAB_MASK_W-1:0] mask_ram [FSAB_DFIF_DEPTH];
	logic [DFIF_IDX_W:0]    wptr;
	logic [DFIF_IDX_W:0]    rptr;

	assign q.empty = (rptr == wptr);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (fsabo_valid)
				wptr <= wptr + 1'b1; // Every beat, reads included
			if (q.pop)
				rptr <= rptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fsabo_valid) begin
			data_ram[wptr[DFIF_IDX_W-1:0]].word <= fsabo_data;
			mask_ram[wptr[DFIF_IDX_W-1:0]] <= fsabo_mask;
		end
		// Head stays put between pops
		if (q.pop) begin
			q.data <= data_ram[rptr[DFIF_IDX_W-1:0]];
			q.mask <= mask_ram[rptr[DFIF_IDX_W-1:0]];
		end
	end

endmodule

/* src/fsab_mem_engine.sv */
`timescale 1ns/1ps

module fsab_mem_engine (
	input  logic                             clk,
	input  logic                             rst_b,
	fsab_req_if.engine                       rq,
	fsab_data_if.engine                      dq,
	output logic                             fsabo_credit,
	output logic                             fsabi_valid,
	output logic [fsab_pkg::FSAB_DID_W-1:0]  fsabi_did,
	output logic [fsab_pkg::FSAB_DID_W-1:0]  fsabi_subdid,
	output logic [fsab_pkg::FSAB_DATA_W-1:0] fsabi_data
);
	import fsab_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		HEAD,         // Header on rq.req, first data pop
		WRITE,
		READ_DISCARD, // Read's dummy data beat lands and is dropped
		READ
	} state_e;

	state_e                state;
	fsab_word_u            mem [MEM_WORDS];
	fsab_word_u            merged;
	logic [MEM_IDX_W-1:0]  idx;        // Next word to store or send
	logic [MEM_IDX_W-1:0]  head_idx;
	logic [MEM_IDX_W-1:0]  rd_idx;
	logic [FSAB_LEN_W-1:0] beats_left; // Stores left for a write, sends left for a read
	logic [FSAB_LEN_W-1:0] pops_left;
	logic                  wr_beat;    // A data beat was popped last cycle
	logic                  head_rd;
	logic                  stream_rd;
	logic                  rd_issue;

	assign head_idx = rq.req.addr[FSAB_BYTE_OFS_W +: MEM_IDX_W]; // Wraps at MEM_WORDS
	assign head_rd = (state == HEAD) && (rq.req.mode == FSAB_READ);
	assign stream_rd = ((state == READ_DISCARD) || (state == READ)) && (beats_left != '0);
	assign rd_issue = head_rd || stream_rd;
	assign rd_idx = head_rd ? head_idx : idx;

	assign rq.pop = (state == IDLE) && !rq.empty;

	// A read's single data beat was pushed with its header, so it is present in HEAD
	assign dq.pop = !dq.empty && ((state == HEAD) || ((state == WRITE) && (pops_left != '0)));

	// Byte lane merge of the popped beat over the stored word
	always_comb begin
		merged = mem[idx];
		for (int i = 0; i < FSAB_MASK_W; i++) begin
			if (dq.mask[i])
				merged.lane[i] = dq.data.lane[i];
		end
	end

	always_ff @(posedge clk) begin
		if ((state == WRITE) && wr_beat)
			mem[idx] <= merged;
		if (rd_issue)
			fsabi_data <= mem[rd_idx].word;
		if (head_rd) begin
			fsabi_did <= rq.req.did;       // Held for the whole burst
			fsabi_subdid <= rq.req.subdid;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state <= IDLE;
			idx <= '0;
			beats_left <= '0;
			pops_left <= '0;
			wr_beat <= 1'b0;
			fsabi_valid <= 1'b0;
			fsabo_credit <= 1'b0;
		end else begin
			wr_beat <= dq.pop;
			fsabi_valid <= rd_issue;
			fsabo_credit <= 1'b0;

			case (state)
			IDLE: begin
				if (rq.pop)
					state <= HEAD;
			end
			HEAD: begin
				if (rq.req.mode == FSAB_READ) begin
					idx <= head_idx + 1'b1; // First word already on its way out
					beats_left <= (rq.req.len > 1) ? rq.req.len - 1'b1 : '0;
					fsabo_credit <= (rq.req.len <= 1);
					state <= READ_DISCARD;
				end else begin
					idx <= head_idx;
					beats_left <= rq.req.len;
					pops_left <= rq.req.len - dq.pop;
					state <= WRITE;
				end
			end
			WRITE: begin
				if (dq.pop)
					pops_left <= pops_left - 1'b1;
				if (wr_beat) begin
					idx <= idx + 1'b1;
					beats_left <= beats_left - 1'b1;
					if (beats_left == 1) begin
						fsabo_credit <= 1'b1; // Last word stored
						state <= IDLE;
					end
				end
			end
			READ_DISCARD, READ: begin
				if (stream_rd) begin
					idx <= idx + 1'b1;
					beats_left <= beats_left - 1'b1;
					fsabo_credit <= (beats_left == 1); // Goes with the last beat
				end
				state <= (beats_left > 1) ? READ : IDLE;
			end
			default: begin
				state <= IDLE;
			end
			endcase
		end
	end

endmodule

/* src/fsab_memory.sv */
`timescale 1ns/1ps

module fsab_memory (
	input  logic                             clk,
	input  logic                             rst_b,

	input  logic                             fsabo_valid,
	input  fsab_pkg::fsab_mode_e             fsabo_mode,
	input  logic [fsab_pkg::FSAB_DID_W-1:0]  fsabo_did,
	input  logic [fsab_pkg::FSAB_DID_W-1:0]  fsabo_subdid,
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] fsabo_addr,
	input  logic [fsab_pkg::FSAB_LEN_W-1:0]  fsabo_len,
	input  logic [fsab_pkg::FSAB_DATA_W-1:0] fsabo_data,
	input  logic [fsab_pkg::FSAB_MASK_W-1:0] fsabo_mask,
	output logic                             fsabo_credit,

	output logic                             fsabi_valid,
	output logic [fsab_pkg::FSAB_DID_W-1:0]  fsabi_did,
	output logic [fsab_pkg::FSAB_DID_W-1:0]  fsabi_subdid,
	output logic [fsab_pkg::FSAB_DATA_W-1:0] fsabi_data
);

	fsab_req_if  req_q ();
	fsab_data_if data_q ();

	// Header beats only
	fsab_req_fifo req_fifo0 (
		.clk          (clk),
		.rst_b        (rst_b),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.q            (req_q.fifo)
	);

	fsab_data_fifo data_fifo0 (
		.clk         (clk),
		.rst_b       (rst_b),
		.fsabo_valid (fsabo_valid),
		.fsabo_data  (fsabo_data),
		.fsabo_mask  (fsabo_mask),
		.q           (data_q.fifo)
	);

	fsab_mem_engine engine0 (
		.clk          (clk),
		.rst_b        (rst_b),
		.rq           (req_q.engine),
		.dq           (data_q.engine),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

endmodule

/* src/fsab_pkg.sv */
package fsab_pkg;

	localparam int FSAB_DATA_W          = 64;
	localparam int FSAB_MASK_W          = 8;  // One enable per data byte
	localparam int FSAB_ADDR_W          = 31; // Byte address
	localparam int FSAB_DID_W           = 4;  // Shared by did and subdid
	localparam int FSAB_LEN_W           = 4;
	localparam int FSAB_LEN_MAX         = 8;  // Beats per burst
	localparam int FSAB_INITIAL_CREDITS = 4;

	// Room for every outstanding request at full burst length
	localparam int FSAB_DFIF_DEPTH      = FSAB_INITIAL_CREDITS * FSAB_LEN_MAX;

	localparam int MEM_WORDS            = 1024;

	localparam int FSAB_BYTE_OFS_W      = $clog2(FSAB_MASK_W); // Byte offset within a word
	localparam int MEM_IDX_W            = $clog2(MEM_WORDS);
	localparam int RFIF_IDX_W           = $clog2(FSAB_INITIAL_CREDITS);
	localparam int DFIF_IDX_W           = $clog2(FSAB_DFIF_DEPTH);

	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_e;

	// Header as kept in the request queue
	typedef struct packed {
		fsab_mode_e             mode;
		logic [FSAB_DID_W-1:0]  did;
		logic [FSAB_DID_W-1:0]  subdid;
		logic [FSAB_ADDR_W-1:0] addr;
		logic [FSAB_LEN_W-1:0]  len;  // Beats, 1 to FSAB_LEN_MAX
	} fsab_req_t;

	typedef union packed {
		logic [FSAB_DATA_W-1:0]      word;
		logic [FSAB_MASK_W-1:0][7:0] lane; // Lane i matches mask bit i
	} fsab_word_u;

endpackage

/* src/fsab_queue_if.sv */
`timescale 1ns/1ps

interface fsab_req_if;
	import fsab_pkg::*;

	fsab_req_t req;   // Head entry, valid the cycle after pop
	logic      empty;
	logic      pop;   // Only while empty is low

	modport fifo (output req, output empty, input pop);
	modport engine (input req, input empty, output pop);

endinterface

interface fsab_data_if;
	import fsab_pkg::*;

	fsab_word_u             data;  // Popped beat, held until the next pop
	logic [FSAB_MASK_W-1:0] mask;
	logic                   empty;
	logic                   pop;

	modport fifo (output data, output mask, output empty, input pop);
	modport engine (input data, input mask, input empty, output pop);

endinterface

/* src/fsab_req_fifo.sv */
`timescale 1ns/1ps

module fsab_req_fifo (
	input  logic                             clk,
	input  logic                             rst_b,
	input  logic                             fsabo_valid,
	input  fsab_pkg::fsab_mode_e             fsabo_mode,
	input  logic [fsab_pkg::FSAB_DID_W-1:0]  fsabo_did,
	input  logic [fsab_pkg::FSAB_DID_W-1:0]  fsabo_subdid,
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] fsabo_addr,
	input  logic [fsab_pkg::FSAB_LEN_W-1:0]  fsabo_len,
	fsab_req_if.fifo                         q
);
	import fsab_pkg::*;

	fsab_req_t             ram [FSAB_INITIAL_CREDITS];
	logic [RFIF_IDX_W:0]   wptr;      // Extra bit tells full from empty
	logic [RFIF_IDX_W:0]   rptr;
	logic [FSAB_LEN_W-1:0] beats_rem; // Write beats of the current burst still to come
	logic                  push;

	// Any beat outside a write burst starts a new request
	assign push = fsabo_valid && (beats_rem == '0);
	assign q.empty = (rptr == wptr);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			beats_rem <= '0;
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push && (fsabo_mode == FSAB_WRITE) && (fsabo_len != '0))
				beats_rem <= fsabo_len - 1'b1; // Header is the first data beat
			else if (fsabo_valid && (beats_rem != '0))
				beats_rem <= beats_rem - 1'b1;

			if (push)
				wptr <= wptr + 1'b1;
			if (q.pop)
				rptr <= rptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			ram[wptr[RFIF_IDX_W-1:0]] <= '{
				mode:   fsabo_mode,
				did:    fsabo_did,
				subdid: fsabo_subdid,
				addr:   fsabo_addr,
				len:    fsabo_len
			};
		end
		if (q.pop)
			q.req <= ram[rptr[RFIF_IDX_W-1:0]];
	end

endmodule

/* tests/tb_fsab_memory.sv */
`timescale 1ns/1ps

module tb_fsab_memory;
	import fsab_pkg::*;

	localparam int TIMEOUT = 500; // Cycles allowed for any single wait

	logic                   clk;
	logic                   rst_b;
	logic                   fsabo_valid;
	fsab_mode_e             fsabo_mode;
	logic [FSAB_DID_W-1:0]  fsabo_did;
	logic [FSAB_DID_W-1:0]  fsabo_subdid;
	logic [FSAB_ADDR_W-1:0] fsabo_addr;
	logic [FSAB_LEN_W-1:0]  fsabo_len;
	logic [FSAB_DATA_W-1:0] fsabo_data;
	logic [FSAB_MASK_W-1:0] fsabo_mask;
	logic                   fsabo_credit;
	logic                   fsabi_valid;
	logic [FSAB_DID_W-1:0]  fsabi_did;
	logic [FSAB_DID_W-1:0]  fsabi_subdid;
	logic [FSAB_DATA_W-1:0] fsabi_data;

	logic [FSAB_DATA_W-1:0] model [MEM_WORDS];          // Starts unknown like the array
	logic [FSAB_DATA_W-1:0] beat_data [FSAB_LEN_MAX];   // Filled by a test before send_req
	logic [FSAB_MASK_W-1:0] beat_mask [FSAB_LEN_MAX];
	logic [FSAB_DATA_W-1:0] exp_data [$];
	logic [FSAB_DID_W-1:0]  exp_did [$];
	logic [FSAB_DID_W-1:0]  exp_subdid [$];
	logic [15:0]            lfsr = 16'd53829;
	int                     credits = FSAB_INITIAL_CREDITS;
	int                     credit_pulses = 0;
	int                     errors = 0;
	int                     pass_count = 0;
	int                     fail_count = 0;

	fsab_memory dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11, one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		logic        fb;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[62:0], fb};
		end
		return r;
	endfunction

	function automatic logic [63:0] merge_lanes(input logic [63:0] old_w, input logic [63:0] new_w,
			input logic [7:0] mask);
		logic [63:0] res;
		int          i;
		res = old_w;
		for (i = 0; i < FSAB_MASK_W; i++) begin
			if (mask[i])
				res[8*i +: 8] = new_w[8*i +: 8];
		end
		return res;
	endfunction

	task automatic check_beat();
		logic [63:0] d;
		logic [3:0]  did;
		logic [3:0]  sub;
		if (exp_data.size() == 0) begin
			$display("Read beat at %0t arrived with no read outstanding", $time);
			errors++;
		end else begin
			d = exp_data.pop_front();
			did = exp_did.pop_front();
			sub = exp_subdid.pop_front();
			assert (fsabi_data === d && fsabi_did === did && fsabi_subdid === sub) else begin
				$display("[ERROR] %0t: beat %h did %h sub %h, expected %h did %h sub %h", $time,
					fsabi_data, fsabi_did, fsabi_subdid, d, did, sub);
				errors++;
			end
		end
	endtask

	// Outputs sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (rst_b) begin
			if (fsabo_credit) begin
				credits++;
				credit_pulses++;
			end
			assert (credits <= FSAB_INITIAL_CREDITS) else begin
				$display("[ERROR] %0t: credit count %0d above the initial credits", $time, credits);
				errors++;
			end
			if (fsabi_valid)
				check_beat();
		end
	end

	task automatic send_req(input fsab_mode_e mode, input logic [3:0] did, input logic [3:0] sub,
			input logic [30:0] addr, input int len);
		int cycles;
		int nbeats;
		int b;
		int widx;
		cycles = 0;
		while (credits == 0 && cycles < TIMEOUT) begin
			@(posedge clk);
			fsabo_valid <= 1'b0; // Bus idles while out of credits
			cycles++;
		end
		if (credits == 0) begin
			$display("Timed out at %0t waiting for a credit", $time);
			errors++;
		end else begin
			credits--;
			nbeats = (mode == FSAB_WRITE) ? len : 1;
			for (b = 0; b < nbeats; b++) begin
				@(posedge clk);
				fsabo_valid <= 1'b1;
				fsabo_mode <= mode;
				fsabo_did <= did;
				fsabo_subdid <= sub;
				fsabo_addr <= addr;
				fsabo_len <= len[FSAB_LEN_W-1:0];
				fsabo_data <= beat_data[b];
				fsabo_mask <= beat_mask[b];
				widx = (int'(addr >> 3) + b) % MEM_WORDS;
				if (mode == FSAB_WRITE)
					model[widx] = merge_lanes(model[widx], beat_data[b], beat_mask[b]);
			end
			// Requests retire in order, so the model is current here
			for (b = 0; b < len && mode == FSAB_READ; b++) begin
				exp_data.push_back(model[(int'(addr >> 3) + b) % MEM_WORDS]);
				exp_did.push_back(did);
				exp_subdid.push_back(sub);
			end
		end
	endtask

	task automatic bus_idle();
		@(posedge clk);
		fsabo_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while ((exp_data.size() != 0 || credits != FSAB_INITIAL_CREDITS) && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_data.size() != 0 || credits != FSAB_INITIAL_CREDITS) begin
			$display("Timed out at %0t: %0d read beats and %0d credits still missing", $time,
				exp_data.size(), FSAB_INITIAL_CREDITS - credits);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		if (errors == err_start) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: failed with %0d errors", name, errors - err_start);
		end
	endtask

	task automatic test_reset_idle();
		int e0;
		e0 = errors;
		repeat (8) begin
			@(negedge clk);
			assert (fsabo_credit === 1'b0 && fsabi_valid === 1'b0) else begin
				$display("[ERROR] %0t: credit %b valid %b on an idle bus", $time, fsabo_credit,
					fsabi_valid);
				errors++;
			end
		end
		end_test("reset_idle", e0);
	endtask

	task automatic test_burst_rw();
		int e0;
		int p0;
		int b;
		e0 = errors;
		p0 = credit_pulses;
		for (b = 0; b < FSAB_LEN_MAX; b++) begin
			beat_data[b] = rand_bits(64);
			beat_mask[b] = 8'hFF;
		end
		send_req(FSAB_WRITE, 4'h3, 4'h5, 31'h100, 8); // Words 32 to 39
		send_req(FSAB_READ, 4'h9, 4'hA, 31'h100, 8);
		bus_idle();
		wait_drain();
		assert (credit_pulses - p0 == 2) else begin
			$display("[ERROR] %0t: %0d credit pulses for 2 requests", $time, credit_pulses - p0);
			errors++;
		end
		end_test("burst_rw", e0);
	endtask

	task automatic test_partial_mask();
		int e0;
		e0 = errors;
		beat_data[0] = 64'h1122_3344_5566_7788;
		beat_data[1] = 64'h99AA_BBCC_DDEE_FF00;
		beat_mask[0] = 8'hFF;
		beat_mask[1] = 8'hFF;
		send_req(FSAB_WRITE, 4'h1, 4'h1, 31'd320, 2); // Words 40 and 41
		beat_data[0] = rand_bits(64);
		beat_data[1] = rand_bits(64);
		beat_mask[0] = 8'h0F;
		beat_mask[1] = 8'h0F;
		send_req(FSAB_WRITE, 4'h1, 4'h1, 31'd320, 2);
		beat_data[0] = rand_bits(64);
		beat_data[1] = rand_bits(64);
		beat_mask[0] = 8'hF0;
		beat_mask[1] = 8'hF0;
		send_req(FSAB_WRITE, 4'h1, 4'h1, 31'd320, 2);
		send_req(FSAB_READ, 4'h6, 4'h2, 31'd320, 2);
		bus_idle();
		wait_drain();
		end_test("partial_mask", e0);
	endtask

	task automatic test_credits();
		int e0;
		int p0;
		int i;
		e0 = errors;
		p0 = credit_pulses;
		for (i = 0; i < FSAB_INITIAL_CREDITS; i++)
			send_req(FSAB_READ, 4'(i + 1), 4'(8 + i), 31'(32'h100 + 16 * i), 2);
		assert (credits == 0) else begin
			$display("[ERROR] %0t: %0d credits left after four requests", $time, credits);
			errors++;
		end
		bus_idle();
		wait_drain();
		assert (credit_pulses - p0 == FSAB_INITIAL_CREDITS) else begin
			$display("[ERROR] %0t: %0d credit pulses for 4 requests", $time, credit_pulses - p0);
			errors++;
		end
		end_test("credits", e0);
	endtask

	// Whole array set to a pattern of its word index
	task automatic fill_memory();
		int w;
		int b;
		for (w = 0; w < MEM_WORDS; w += FSAB_LEN_MAX) begin
			for (b = 0; b < FSAB_LEN_MAX; b++) begin
				beat_data[b] = {~32'(w + b), 32'(w + b) ^ 32'hC3A5_0000};
				beat_mask[b] = 8'hFF;
			end
			send_req(FSAB_WRITE, 4'h0, 4'h0, 31'(w * 8), FSAB_LEN_MAX);
		end
	endtask

	task automatic test_random();
		int               e0;
		int               i;
		int               b;
		int               len;
		logic [30:0]      addr;
		logic [3:0]       did;
		logic [3:0]       sub;
		fsab_mode_e       mode;
		e0 = errors;
		fill_memory();
		for (i = 0; i < 20; i++) begin
			mode = fsab_mode_e'(1'(rand_bits(1)));
			addr = 31'(rand_bits(31));
			len = int'(rand_bits(3)) + 1;
			if (i % 4 == 3) begin
				addr[12:3] = 10'(MEM_WORDS - 3); // Burst runs off the top of the array
				len = FSAB_LEN_MAX;
			end
			did = 4'(rand_bits(4));
			sub = 4'(rand_bits(4));
			for (b = 0; b < len; b++) begin
				beat_data[b] = rand_bits(64);
				beat_mask[b] = 8'(rand_bits(8));
			end
			send_req(mode, did, sub, addr, len);
		end
		bus_idle();
		wait_drain();
		end_test("random", e0);
	endtask

	initial begin
		rst_b = 1'b0;
		fsabo_valid = 1'b0;
		fsabo_mode = FSAB_READ;
		fsabo_did = '0;
		fsabo_subdid = '0;
		fsabo_addr = '0;
		fsabo_len = '0;
		fsabo_data = '0;
		fsabo_mask = '0;
		repeat (3) @(posedge clk);
		rst_b <= 1'b1;
		test_reset_idle();
		test_burst_rw();
		test_partial_mask();
		test_credits();
		test_random();
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (errors == 0 && fail_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
